// File: src/cpuCtrlPkg.sv
package cpuCtrlPkg;

   localparam int OpcodeWidth = 4;
   localparam int FunctWidth  = 4;

   // Instruction phases
   typedef enum logic [4:0] {
      Fetch      = 5'd0,
      Decode     = 5'd1,
      AExec      = 5'd2,
      CExec      = 5'd3,
      MemAddr    = 5'd4,
      BeqExec    = 5'd5,
      BneExec    = 5'd6,
      JumpExec   = 5'd7,
      JrExec     = 5'd8,
      JalExec    = 5'd9,
      LuiExec    = 5'd10,
      AWrite     = 5'd11,
      CWrite     = 5'd12,
      LoadRead   = 5'd13,
      StoreWrite = 5'd14,
      JalWrite   = 5'd15,
      LoadWrite  = 5'd16,
      Move       = 5'd17,
      Clear      = 5'd18,
      MemToLcd   = 5'd19,
      LcdShow    = 5'd20
   } stateT;

   typedef enum logic [3:0] {
      ClassA,
      ClassC,
      ClassLoad,
      ClassStore,
      ClassLui,
      ClassBeq,
      ClassBne,
      ClassJal,
      ClassJump,
      ClassJr,
      ClassMove,
      ClassClear,
      ClassMemLcd,
      ClassLcd,
      ClassNone
   } instrClassT;

   typedef enum logic [2:0] {
      AluAnd = 3'd0,
      AluOr  = 3'd1,
      AluAdd = 3'd2,
      AluSub = 3'd6,
      AluSlt = 3'd7
   } aluOpT;

   typedef enum logic [2:0] {
      PcAluOut     = 3'd0,
      PcAluResult  = 3'd1,
      PcBranch     = 3'd2,
      PcEpcVector  = 3'd3,
      PcClear      = 3'd4,
      PcJumpTarget = 3'd5
   } pcSrcT;

   typedef enum logic [1:0] {AddrPc = 2'd0, AddrAlu = 2'd1, AddrLcd = 2'd2} addrSrcT;

   typedef enum logic [1:0] {DstRt = 2'd0, DstLoad = 2'd1, DstRd = 2'd2, DstLink = 2'd3} regDstT;

   // Move source sits apart from the datapath results
   typedef enum logic [2:0] {
      DataAlu    = 3'd0,
      DataMem    = 3'd1,
      DataAluOut = 3'd2,
      DataMove   = 3'd4
   } regDataT;

   typedef enum logic [1:0] {BReg = 2'd0, BFour = 2'd1, BImm = 2'd2, BLink = 2'd3} aluBSrcT;

endpackage

// File: src/instrClassDecode.sv
`timescale 1ns/1ps

module instrClassDecode (
   input  logic [cpuCtrlPkg::OpcodeWidth-1:0] Opcode,
   input  logic [cpuCtrlPkg::FunctWidth-1:0]  Functioncode,
   output cpuCtrlPkg::instrClassT             Class,
   output cpuCtrlPkg::aluOpT                  ExecAluOp
);
   import cpuCtrlPkg::*;

   always_comb
   begin
      case (Opcode)
         4'd0, 4'd1, 4'd2, 4'd3, 4'd7: Class = ClassA;
         4'd4, 4'd6:                   Class = ClassC;
         4'd5:
         begin
            // System functions
            case (Functioncode)
               4'd0:    Class = ClassMove;
               4'd1:    Class = ClassClear;
               4'd2:    Class = ClassMemLcd;
               4'd3:    Class = ClassLcd;
               default: Class = ClassNone;
            endcase
         end
         4'd8:    Class = ClassLoad;
         4'd9:    Class = ClassStore;
         4'd10:   Class = ClassLui;
         4'd11:   Class = ClassBeq;
         4'd12:   Class = ClassBne;
         4'd13:   Class = ClassJal;
         4'd14:   Class = ClassJump;
         default: Class = ClassJr;     // Opcode 15
      endcase
   end

   // ALU op used by AExec and CExec
   always_comb
   begin
      case (Opcode)
         4'd0:    ExecAluOp = AluAdd;
         4'd1:    ExecAluOp = AluSub;
         4'd2:    ExecAluOp = AluAnd;
         4'd3:    ExecAluOp = AluOr;
         4'd4:    ExecAluOp = AluAdd;   // addi
         4'd6:    ExecAluOp = AluOr;    // ori
         4'd7:    ExecAluOp = AluSlt;
         default: ExecAluOp = AluAnd;
      endcase
   end

endmodule

// File: src/stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer (
   input  logic                   CLK,
   input  logic                   Reset,
   input  cpuCtrlPkg::instrClassT Class,
   output cpuCtrlPkg::stateT      State
);
   import cpuCtrlPkg::*;

   stateT nextState;

   always_ff @(posedge CLK or posedge Reset)
   begin
      if (Reset)
      begin
         State <= Fetch;
      end
      else
      begin
         State <= nextState;
      end
   end

   always_comb
   begin
      nextState = Fetch;   // Final phases fall back here
      case (State)
         Fetch: nextState = Decode;
         Decode:
         begin
            case (Class)
               ClassA:               nextState = AExec;
               ClassC:               nextState = CExec;
               ClassLoad, ClassStore: nextState = MemAddr;
               ClassLui:             nextState = LuiExec;
               ClassBeq:             nextState = BeqExec;
               ClassBne:             nextState = BneExec;
               ClassJal:             nextState = JalExec;
               ClassJump:            nextState = JumpExec;
               ClassJr:              nextState = JrExec;
               ClassMove:            nextState = Move;
               ClassClear:           nextState = Clear;
               ClassMemLcd:          nextState = MemToLcd;
               ClassLcd:             nextState = LcdShow;
               default:              nextState = Fetch;   // Unused system function
            endcase
         end
         MemAddr:
         begin
            if (Class == ClassStore)
            begin
               nextState = StoreWrite;
            end
            else
            begin
               nextState = LoadRead;
            end
         end
         AExec:    nextState = AWrite;
         CExec:    nextState = CWrite;
         LoadRead: nextState = LoadWrite;
         JalExec:  nextState = JalWrite;
         default:  nextState = Fetch;
      endcase
   end

endmodule

// File: src/controlWordDecode.sv
`timescale 1ns/1ps

module controlWordDecode (
   input  cpuCtrlPkg::stateT   State,
   input  cpuCtrlPkg::aluOpT   ExecAluOp,
   input  logic                InterruptIn,
   input  logic                InterruptHandler,
   output cpuCtrlPkg::aluOpT   ALUOp,
   output logic                PCWriteBeq,
   output logic                PCWriteBne,
   output logic                PCWrite,
   output cpuCtrlPkg::addrSrcT IorD,
   output logic                IRegWrite,
   output cpuCtrlPkg::regDstT  WriteAddr,
   output cpuCtrlPkg::regDataT WriteData,
   output logic                SignExt,
   output logic                GRegWrite,
   output logic                ALUSrcA,
   output cpuCtrlPkg::aluBSrcT ALUSrcB,
   output cpuCtrlPkg::pcSrcT   PCData,
   output logic                MemRead,
   output logic                MemWrite,
   output logic [1:0]          MemWriteData,
   output logic                EPCWrite,
   output logic                CLR,
   output logic                LCDWrite
);
   import cpuCtrlPkg::*;

   always_comb
   begin
      // Everything inactive unless the phase says otherwise
      ALUOp        = AluAnd;
      PCWriteBeq   = 1'b0;
      PCWriteBne   = 1'b0;
      PCWrite      = 1'b0;
      IorD         = AddrPc;
      IRegWrite    = 1'b0;
      WriteAddr    = DstRt;
      WriteData    = DataAlu;
      SignExt      = 1'b0;
      GRegWrite    = 1'b0;
      ALUSrcA      = 1'b0;
      ALUSrcB      = BReg;
      PCData       = PcAluOut;
      MemRead      = 1'b0;
      MemWrite     = 1'b0;
      MemWriteData = 2'd0;
      EPCWrite     = 1'b0;
      CLR          = 1'b0;
      LCDWrite     = 1'b0;

      case (State)
         Fetch:
         begin
            ALUOp     = AluAdd;   // PC + 4
            ALUSrcB   = BFour;
            PCWrite   = 1'b1;
            IRegWrite = 1'b1;
            MemRead   = 1'b1;
            // Take the interrupt only when not already in the handler
            if (InterruptIn && !InterruptHandler)
            begin
               EPCWrite = 1'b1;
               PCData   = PcEpcVector;
            end
            else
            begin
               PCData = PcAluResult;
            end
         end
         Decode:
         begin
            ALUOp   = AluAdd;   // Branch target
            SignExt = 1'b1;
            ALUSrcB = BImm;
         end
         AExec:
         begin
            ALUOp   = ExecAluOp;
            ALUSrcA = 1'b1;
         end
         CExec:
         begin
            ALUOp   = ExecAluOp;
            ALUSrcA = 1'b1;
            ALUSrcB = BImm;
         end
         MemAddr:
         begin
            ALUOp   = AluAdd;
            SignExt = 1'b1;
            ALUSrcA = 1'b1;
            ALUSrcB = BImm;
         end
         BeqExec, BneExec:
         begin
            ALUOp      = AluSub;   // Compare by subtraction
            ALUSrcA    = 1'b1;
            PCData     = PcBranch;
            PCWriteBeq = (State == BeqExec);
            PCWriteBne = (State == BneExec);
         end
         JumpExec:
         begin
            PCWrite = 1'b1;
            PCData  = PcJumpTarget;
         end
         JrExec:  PCWrite = 1'b1;   // PC from the register operand
         JalExec:
         begin
            ALUOp   = AluAdd;   // Return address
            ALUSrcB = BLink;
         end
         LuiExec: GRegWrite = 1'b1;
         AWrite:
         begin
            WriteAddr = DstRd;
            WriteData = DataAluOut;
            GRegWrite = 1'b1;
         end
         CWrite:
         begin
            WriteData = DataAluOut;
            GRegWrite = 1'b1;
         end
         LoadRead:
         begin
            IorD    = AddrAlu;
            MemRead = 1'b1;
         end
         StoreWrite:
         begin
            IorD      = AddrAlu;
            WriteData = DataMem;
            MemWrite  = 1'b1;
         end
         JalWrite:
         begin
            PCWrite   = 1'b1;
            PCData    = PcJumpTarget;
            WriteAddr = DstLink;
            WriteData = DataAluOut;
            GRegWrite = 1'b1;
         end
         LoadWrite:
         begin
            WriteAddr = DstLoad;
            WriteData = DataMem;
            GRegWrite = 1'b1;
         end
         Move:
         begin
            WriteData = DataMove;
            GRegWrite = 1'b1;
         end
         Clear:
         begin
            PCWrite = 1'b1;
            PCData  = PcClear;
            CLR     = 1'b1;
         end
         MemToLcd:
         begin
            IorD         = AddrLcd;
            MemWrite     = 1'b1;
            MemWriteData = 2'd1;   // Display buffer data
         end
         LcdShow:
         begin
            IorD     = AddrLcd;
            MemRead  = 1'b1;
            LCDWrite = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// File: src/multicycleControl.sv
`timescale 1ns/1ps

module multicycleControl (
   input  logic                               CLK,
   input  logic                               Reset,
   input  logic [cpuCtrlPkg::OpcodeWidth-1:0] Opcode,
   input  logic [cpuCtrlPkg::FunctWidth-1:0]  Functioncode,
   input  logic                               InterruptIn,
   input  logic                               InterruptHandler,
   output cpuCtrlPkg::aluOpT                  ALUOp,
   output logic                               PCWriteBeq,
   output logic                               PCWriteBne,
   output logic                               PCWrite,
   output cpuCtrlPkg::addrSrcT                IorD,
   output logic                               IRegWrite,
   output cpuCtrlPkg::regDstT                 WriteAddr,
   output cpuCtrlPkg::regDataT                WriteData,
   output logic                               SignExt,
   output logic                               GRegWrite,
   output logic                               ALUSrcA,
   output cpuCtrlPkg::aluBSrcT                ALUSrcB,
   output cpuCtrlPkg::pcSrcT                  PCData,
   output logic                               MemRead,
   output logic                               MemWrite,
   output logic [1:0]                         MemWriteData,
   output logic                               EPCWrite,
   output logic                               CLR,
   output logic                               LCDWrite,
   output cpuCtrlPkg::stateT                  State
);
   import cpuCtrlPkg::*;

   instrClassT instrClass;
   aluOpT      execAluOp;

   instrClassDecode i_classDecode (
      .Opcode       (Opcode),
      .Functioncode (Functioncode),
      .Class        (instrClass),
      .ExecAluOp    (execAluOp)
   );

   stateSequencer i_sequencer (
      .CLK   (CLK),
      .Reset (Reset),
      .Class (instrClass),
      .State (State)
   );

   controlWordDecode i_wordDecode (
      .State            (State),
      .ExecAluOp        (execAluOp),
      .InterruptIn      (InterruptIn),
      .InterruptHandler (InterruptHandler),
      .ALUOp            (ALUOp),
      .PCWriteBeq       (PCWriteBeq),
      .PCWriteBne       (PCWriteBne),
      .PCWrite          (PCWrite),
      .IorD             (IorD),
      .IRegWrite        (IRegWrite),
      .WriteAddr        (WriteAddr),
      .WriteData        (WriteData),
      .SignExt          (SignExt),
      .GRegWrite        (GRegWrite),
      .ALUSrcA          (ALUSrcA),
      .ALUSrcB          (ALUSrcB),
      .PCData           (PCData),
      .MemRead          (MemRead),
      .MemWrite         (MemWrite),
      .MemWriteData     (MemWriteData),
      .EPCWrite         (EPCWrite),
      .CLR              (CLR),
      .LCDWrite         (LCDWrite)
   );

endmodule

// File: tests/multicycleControl_chk.sv
`timescale 1ns/1ps

module multicycleControl_chk (
   input logic              CLK,
   input logic              Reset,
   input cpuCtrlPkg::stateT State,
   input logic              MemRead,
   input logic              MemWrite,
   input logic              PCWrite,
   input logic              PCWriteBeq,
   input logic              PCWriteBne,
   input logic              EPCWrite
);
   import cpuCtrlPkg::*;

   int memFails   = 0;
   int pcFails    = 0;
   int epcFails   = 0;
   int stateFails = 0;
   int failTotal;

   always_comb failTotal = memFails + pcFails + epcFails + stateFails;

   memExclusive: assert property (@(posedge CLK) disable iff (Reset) !(MemRead && MemWrite))
   else
   begin
      memFails++;
      $error("MemRead and MemWrite high together");
   end

   pcWriteOneHot: assert property (@(posedge CLK) disable iff (Reset)
                                   $onehot0({PCWrite, PCWriteBeq, PCWriteBne}))
   else
   begin
      pcFails++;
      $error("more than one PC write strobe high");
   end

   epcOnlyInFetch: assert property (@(posedge CLK) disable iff (Reset)
                                    EPCWrite |-> State == Fetch)
   else
   begin
      epcFails++;
      $error("EPCWrite high outside Fetch");
   end

   // Every fetch is followed by a decode
   fetchThenDecode: assert property (@(posedge CLK) disable iff (Reset)
                                     State == Fetch |=> State == Decode)
   else
   begin
      stateFails++;
      $error("Fetch not followed by Decode");
   end

endmodule

bind multicycleControl multicycleControl_chk i_chk (
   .CLK        (CLK),
   .Reset      (Reset),
   .State      (State),
   .MemRead    (MemRead),
   .MemWrite   (MemWrite),
   .PCWrite    (PCWrite),
   .PCWriteBeq (PCWriteBeq),
   .PCWriteBne (PCWriteBne),
   .EPCWrite   (EPCWrite)
);

// File: tests/multicycleControlTb.sv
`timescale 1ns/1ps

module multicycleControlTb;
   import cpuCtrlPkg::*;

   logic                   CLK = 1'b0;
   logic                   Reset;
   logic [OpcodeWidth-1:0] Opcode;
   logic [FunctWidth-1:0]  Functioncode;
   logic                   InterruptIn;
   logic                   InterruptHandler;
   aluOpT                  ALUOp;
   logic                   PCWriteBeq;
   logic                   PCWriteBne;
   logic                   PCWrite;
   addrSrcT                IorD;
   logic                   IRegWrite;
   regDstT                 WriteAddr;
   regDataT                WriteData;
   logic                   SignExt;
   logic                   GRegWrite;
   logic                   ALUSrcA;
   aluBSrcT                ALUSrcB;
   pcSrcT                  PCData;
   logic                   MemRead;
   logic                   MemWrite;
   logic [1:0]             MemWriteData;
   logic                   EPCWrite;
   logic                   CLR;
   logic                   LCDWrite;
   stateT                  State;

   string       nameList[$];
   logic [3:0]  opList[$];
   logic [3:0]  fnList[$];
   logic        irqList[$];
   logic        hndList[$];
   int          cycList[$];        // -1 where the rules give the count
   logic [15:0] lfsr = 16'd18713;
   bit          stimLoaded = 1'b0;
   string       curName;
   int          testFailed;
   int          passCount = 0;
   int          failCount = 0;

   multicycleControl i_dut (.*);

   always #20 CLK = ~CLK;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrStep(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic drawBits(output logic [3:0] value);
      value = 4'd0;
      for (int b = 0; b < 4; b++)
      begin
         lfsr  = lfsrStep(lfsr);
         value = {value[2:0], lfsr[0]};
      end
   endtask

   // Fetch to Fetch
   function automatic int expCycles(input logic [3:0] op, input logic [3:0] fn);
      case (op)
         4'd8:                              return 5;
         4'd10, 4'd11, 4'd12, 4'd14, 4'd15: return 3;
         4'd5:                              return (fn < 4'd4) ? 3 : 2;
         default:                           return 4;   // A, C, store, jal
      endcase
   endfunction

   function automatic aluOpT expAluOp(input logic [3:0] op);
      case (op)
         4'd0, 4'd4: return AluAdd;
         4'd1:       return AluSub;
         4'd3, 4'd6: return AluOr;
         4'd7:       return AluSlt;
         default:    return AluAnd;
      endcase
   endfunction

   // Phase right after Decode
   function automatic stateT expExecState(input logic [3:0] op, input logic [3:0] fn);
      case (op)
         4'd0, 4'd1, 4'd2, 4'd3, 4'd7: return AExec;
         4'd4, 4'd6:                   return CExec;
         4'd5:
            case (fn)
               4'd0:    return Move;
               4'd1:    return Clear;
               4'd2:    return MemToLcd;
               4'd3:    return LcdShow;
               default: return Fetch;
            endcase
         4'd8, 4'd9: return MemAddr;
         4'd10:      return LuiExec;
         4'd11:      return BeqExec;
         4'd12:      return BneExec;
         4'd13:      return JalExec;
         4'd14:      return JumpExec;
         default:    return JrExec;
      endcase
   endfunction

   // Phase after the execute phase, Fetch where the instruction ends there
   function automatic stateT expSecondState(input logic [3:0] op);
      case (op)
         4'd0, 4'd1, 4'd2, 4'd3, 4'd7: return AWrite;
         4'd4, 4'd6:                   return CWrite;
         4'd8:                         return LoadRead;
         4'd9:                         return StoreWrite;
         4'd13:                        return JalWrite;
         default:                      return Fetch;
      endcase
   endfunction

   task automatic reportMismatch(input string what, input int expected, input int actual);
      $display("error %s %s expected %0d actual %0d", curName, what, expected, actual);
      testFailed = 1;
   endtask

   task automatic loadStim();
      int         fd;
      int         irqVal;
      int         hndVal;
      string      line;
      string      name;
      string      opTok;
      string      fnTok;
      string      cycTok;
      logic [3:0] op;
      logic [3:0] fn;
      fd = $fopen("tests/multicycleControl_stim.txt", "r");
      if (fd == 0)
      begin
         $display("stimulus file tests/multicycleControl_stim.txt could not be opened");
         failCount++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != 8'h23 &&
                $sscanf(line, "%s %s %s %d %d %s", name, opTok, fnTok, irqVal, hndVal,
                        cycTok) == 6)
            begin
               // Opcode drawn before function code
               if (opTok == "r") drawBits(op);
               else op = 4'(opTok.atoi());
               if (fnTok == "r") drawBits(fn);
               else fn = 4'(fnTok.atoi());
               nameList.push_back(name);
               opList.push_back(op);
               fnList.push_back(fn);
               irqList.push_back(irqVal != 0);
               hndList.push_back(hndVal != 0);
               cycList.push_back((cycTok == "-") ? -1 : cycTok.atoi());
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic finishTest();
      if (testFailed != 0)
      begin
         failCount++;
         $display("test %s failed", curName);
      end
      else
      begin
         passCount++;
         $display("test %s passed", curName);
      end
   endtask

   task automatic checkFetch(input logic irq, input logic hnd);
      if (State !== Fetch) reportMismatch("State", int'(Fetch), int'(State));
      if (PCWrite !== 1'b1) reportMismatch("PCWrite", 1, int'(PCWrite));
      if (IRegWrite !== 1'b1) reportMismatch("IRegWrite", 1, int'(IRegWrite));
      if (MemRead !== 1'b1) reportMismatch("MemRead", 1, int'(MemRead));
      if (IorD !== AddrPc) reportMismatch("IorD", int'(AddrPc), int'(IorD));
      if (ALUOp !== AluAdd) reportMismatch("ALUOp", int'(AluAdd), int'(ALUOp));
      if (ALUSrcA !== 1'b0) reportMismatch("ALUSrcA", 0, int'(ALUSrcA));
      if (ALUSrcB !== BFour) reportMismatch("ALUSrcB", int'(BFour), int'(ALUSrcB));
      if (irq && !hnd)
      begin
         if (EPCWrite !== 1'b1) reportMismatch("EPCWrite", 1, int'(EPCWrite));
         if (PCData !== PcEpcVector) reportMismatch("PCData", int'(PcEpcVector), int'(PCData));
      end
      else
      begin
         if (EPCWrite !== 1'b0) reportMismatch("EPCWrite", 0, int'(EPCWrite));
         if (PCData !== PcAluResult) reportMismatch("PCData", int'(PcAluResult), int'(PCData));
      end
   endtask

   task automatic checkPhase(input logic [3:0] op);
      case (State)
         Decode:
         begin
            if (ALUOp !== AluAdd) reportMismatch("ALUOp", int'(AluAdd), int'(ALUOp));
            if (SignExt !== 1'b1) reportMismatch("SignExt", 1, int'(SignExt));
            if (ALUSrcB !== BImm) reportMismatch("ALUSrcB", int'(BImm), int'(ALUSrcB));
         end
         AExec:
         begin
            if (ALUOp !== expAluOp(op))
               reportMismatch("ALUOp", int'(expAluOp(op)), int'(ALUOp));
            if (ALUSrcA !== 1'b1) reportMismatch("ALUSrcA", 1, int'(ALUSrcA));
            if (ALUSrcB !== BReg) reportMismatch("ALUSrcB", int'(BReg), int'(ALUSrcB));
         end
         CExec:
         begin
            if (ALUOp !== expAluOp(op))
               reportMismatch("ALUOp", int'(expAluOp(op)), int'(ALUOp));
            if (ALUSrcA !== 1'b1) reportMismatch("ALUSrcA", 1, int'(ALUSrcA));
            if (ALUSrcB !== BImm) reportMismatch("ALUSrcB", int'(BImm), int'(ALUSrcB));
         end
         MemAddr:
         begin
            if (ALUOp !== AluAdd) reportMismatch("ALUOp", int'(AluAdd), int'(ALUOp));
            if (ALUSrcB !== BImm) reportMismatch("ALUSrcB", int'(BImm), int'(ALUSrcB));
         end
         JalExec:
            if (ALUOp !== AluAdd) reportMismatch("ALUOp", int'(AluAdd), int'(ALUOp));
         BeqExec:
         begin
            if (ALUOp !== AluSub) reportMismatch("ALUOp", int'(AluSub), int'(ALUOp));
            if (PCWriteBeq !== 1'b1) reportMismatch("PCWriteBeq", 1, int'(PCWriteBeq));
         end
         BneExec:
         begin
            if (ALUOp !== AluSub) reportMismatch("ALUOp", int'(AluSub), int'(ALUOp));
            if (PCWriteBne !== 1'b1) reportMismatch("PCWriteBne", 1, int'(PCWriteBne));
         end
         AWrite:
         begin
            if (GRegWrite !== 1'b1) reportMismatch("GRegWrite", 1, int'(GRegWrite));
            if (WriteAddr !== DstRd) reportMismatch("WriteAddr", int'(DstRd), int'(WriteAddr));
         end
         JalWrite:
         begin
            if (GRegWrite !== 1'b1) reportMismatch("GRegWrite", 1, int'(GRegWrite));
            if (WriteAddr !== DstLink)
               reportMismatch("WriteAddr", int'(DstLink), int'(WriteAddr));
         end
         LoadRead:
         begin
            if (MemRead !== 1'b1) reportMismatch("MemRead", 1, int'(MemRead));
            if (IorD !== AddrAlu) reportMismatch("IorD", int'(AddrAlu), int'(IorD));
         end
         LoadWrite:
         begin
            if (GRegWrite !== 1'b1) reportMismatch("GRegWrite", 1, int'(GRegWrite));
            if (WriteData !== DataMem) reportMismatch("WriteData", int'(DataMem), int'(WriteData));
            if (WriteAddr !== DstLoad)
               reportMismatch("WriteAddr", int'(DstLoad), int'(WriteAddr));
         end
         StoreWrite:
            if (MemWrite !== 1'b1) reportMismatch("MemWrite", 1, int'(MemWrite));
         MemToLcd:
         begin
            if (MemWrite !== 1'b1) reportMismatch("MemWrite", 1, int'(MemWrite));
            if (MemWriteData !== 2'd1) reportMismatch("MemWriteData", 1, int'(MemWriteData));
         end
         LcdShow:
         begin
            if (MemRead !== 1'b1) reportMismatch("MemRead", 1, int'(MemRead));
            if (LCDWrite !== 1'b1) reportMismatch("LCDWrite", 1, int'(LCDWrite));
            if (IorD !== AddrLcd) reportMismatch("IorD", int'(AddrLcd), int'(IorD));
         end
         Clear:
         begin
            if (CLR !== 1'b1) reportMismatch("CLR", 1, int'(CLR));
            if (PCWrite !== 1'b1) reportMismatch("PCWrite", 1, int'(PCWrite));
            if (PCData !== PcClear) reportMismatch("PCData", int'(PcClear), int'(PCData));
         end
         Move:
         begin
            if (GRegWrite !== 1'b1) reportMismatch("GRegWrite", 1, int'(GRegWrite));
            if (WriteData !== DataMove) reportMismatch("WriteData", int'(DataMove), int'(WriteData));
         end
         default: ;
      endcase
   endtask

   task automatic checkResetWord();
      curName    = "reset";
      testFailed = 0;
      checkFetch(1'b0, 1'b0);
      if (PCWriteBeq !== 1'b0) reportMismatch("PCWriteBeq", 0, int'(PCWriteBeq));
      if (PCWriteBne !== 1'b0) reportMismatch("PCWriteBne", 0, int'(PCWriteBne));
      if (GRegWrite !== 1'b0) reportMismatch("GRegWrite", 0, int'(GRegWrite));
      if (MemWrite !== 1'b0) reportMismatch("MemWrite", 0, int'(MemWrite));
      if (LCDWrite !== 1'b0) reportMismatch("LCDWrite", 0, int'(LCDWrite));
      if (CLR !== 1'b0) reportMismatch("CLR", 0, int'(CLR));
      finishTest();
   endtask

   // Starts in a Fetch cycle, ends in the next Fetch
   task automatic runTest(input int idx);
      int    cycles;
      int    expected;
      stateT expState;
      curName    = nameList[idx];
      testFailed = 0;
      expected   = expCycles(opList[idx], fnList[idx]);
      if (cycList[idx] >= 0 && cycList[idx] != expected)
         reportMismatch("stim cycles", expected, cycList[idx]);
      @(posedge CLK);
      Opcode           <= opList[idx];
      Functioncode     <= fnList[idx];
      InterruptIn      <= irqList[idx];
      InterruptHandler <= hndList[idx];
      cycles = 1;
      @(negedge CLK);
      while (State != Fetch && cycles < 8)
      begin
         cycles++;
         case (cycles)
            2:       expState = Decode;
            3:       expState = expExecState(opList[idx], fnList[idx]);
            4:       expState = expSecondState(opList[idx]);
            5:       expState = (opList[idx] == 4'd8) ? LoadWrite : Fetch;
            default: expState = Fetch;
         endcase
         if (State !== expState) reportMismatch("State", int'(expState), int'(State));
         checkPhase(opList[idx]);
         @(negedge CLK);
      end
      if (State != Fetch)
      begin
         $display("%s did not return to Fetch within 8 cycles", curName);
         testFailed = 1;
      end
      else
      begin
         if (cycles != expected) reportMismatch("cycles", expected, cycles);
         checkFetch(irqList[idx], hndList[idx]);
      end
      finishTest();
   endtask

   initial
   begin
      Reset            = 1'b1;
      Opcode           = '0;
      Functioncode     = '0;
      InterruptIn      = 1'b0;
      InterruptHandler = 1'b0;
      loadStim();
      stimLoaded = 1'b1;
      repeat (8) @(posedge CLK);
      Reset <= 1'b0;
      @(negedge CLK);
      checkResetWord();
      for (int i = 0; i < nameList.size(); i++)
         runTest(i);
      $display("tests %0d passed %0d failed %0d assertion failures %0d",
               passCount + failCount, passCount, failCount, i_dut.i_chk.failTotal);
      if (failCount == 0 && i_dut.i_chk.failTotal == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // Six cycles per test is above the longest instruction
   initial
   begin
      wait (stimLoaded);
      #((nameList.size() * 6 + 8) * 40);
      $display("watchdog expired before all tests finished");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: tests/multicycleControl_stim.txt
# name opcode funct interrupt handler cycles (decimal fields)
# r draws the field from the LFSR, - takes the cycle count from the rules
addA 0 0 0 0 4
subA 1 0 0 0 4
andA 2 0 0 0 4
orA 3 0 0 0 4
addiC 4 0 1 0 4
oriC 6 0 1 1 4
sltA 7 0 0 1 4
load 8 0 0 0 5
store 9 0 0 0 4
lui 10 0 0 0 3
beq 11 0 0 0 3
bne 12 0 0 0 3
jal 13 0 0 0 4
jump 14 0 0 0 3
jr 15 0 1 0 3
move 5 0 0 0 3
clear 5 1 0 0 3
memLcd 5 2 0 0 3
lcdShow 5 3 0 0 3
sysUnused 5 9 0 0 2
rand0 r r 0 0 -
rand1 r r 0 0 -
rand2 r r 0 1 -
rand3 r r 1 0 -
rand4 r r 0 0 -
rand5 r r 0 0 -
rand6 r r 1 1 -
rand7 r r 0 0 -
rand8 r r 1 0 -
rand9 r r 0 0 -

// File: compile.f
src/cpuCtrlPkg.sv
src/instrClassDecode.sv
src/stateSequencer.sv
src/controlWordDecode.sv
src/multicycleControl.sv
tests/multicycleControl_chk.sv
tests/multicycleControlTb.sv

// File: Makefile
TOP = multicycleControlTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f src/*.sv tests/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --top-module multicycleControl src/cpuCtrlPkg.sv \
		src/instrClassDecode.sv src/stateSequencer.sv src/controlWordDecode.sv \
		src/multicycleControl.sv

clean:
	rm -rf obj_dir sim.log
